//--- Makefile
# Verilator flow for the JTAG TAP controller and its testbench

.PHONY: all lint clean

# Build, run, and pass only when the pass line shows up in the output
all:
	verilator --binary --timing --assert -f project.f --top-module tb_jtag_tap
	@out=$$(./obj_dir/Vtb_jtag_tap); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

# Lint the RTL top level
lint:
	verilator --lint-only --timing -Wall -f project.f --top-module jtag_tap

clean:
	rm -rf obj_dir

//--- bench/tb_jtag_tap.sv
// Directed testbench for the JTAG TAP controller, walking the TAP graph and checking TDO
`timescale 1ns/10ps

module tb_jtag_tap;
  import jtag_pkg::*;

  localparam logic [31:0] IDCODE_VAL    = 32'h149511C3;
  localparam int          PADOE_TIMEOUT = 4;

  logic tck_pad_i;
  logic trst_pad_i;
  logic tms_pad_i;
  logic tdi_pad_i;
  logic debug_tdi_i;
  logic dtmcs_tdi_i;
  logic dmi_tdi_i;
  logic tdo_pad_o;
  logic tdo_padoe_o;
  logic shift_dr_o;
  logic pause_dr_o;
  logic update_dr_o;
  logic capture_dr_o;
  logic debug_select_o;
  logic dtmcs_select_o;
  logic dmi_select_o;
  logic tdo_o;

  int cap_count = 0;
  int upd_count = 0;

  jtag_tap #(
    .IDCODE_VALUE (IDCODE_VAL)
  ) UUT (
    .tck_pad_i      (tck_pad_i),
    .trst_pad_i     (trst_pad_i),
    .tms_pad_i      (tms_pad_i),
    .tdi_pad_i      (tdi_pad_i),
    .tdo_pad_o      (tdo_pad_o),
    .tdo_padoe_o    (tdo_padoe_o),
    .shift_dr_o     (shift_dr_o),
    .pause_dr_o     (pause_dr_o),
    .update_dr_o    (update_dr_o),
    .capture_dr_o   (capture_dr_o),
    .debug_select_o (debug_select_o),
    .dtmcs_select_o (dtmcs_select_o),
    .dmi_select_o   (dmi_select_o),
    .tdo_o          (tdo_o),
    .debug_tdi_i    (debug_tdi_i),
    .dtmcs_tdi_i    (dtmcs_tdi_i),
    .dmi_tdi_i      (dmi_tdi_i)
  );

  // 20 ns TCK
  initial
  begin
    tck_pad_i = 1'b0;
    forever #10 tck_pad_i = ~tck_pad_i;
  end

  // Cycles spent in Capture-DR and Update-DR, sampled while the state is stable
  always @(negedge tck_pad_i)
  begin
    if (capture_dr_o)
      cap_count <= cap_count + 1;
    if (update_dr_o)
      upd_count <= upd_count + 1;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Drive on the falling edge, return mid low phase where TDO is settled
  task automatic step(input logic tms, input logic tdi);
    @(negedge tck_pad_i);
    tms_pad_i = tms;
    tdi_pad_i = tdi;
    #5;
  endtask

  // Pad enable follows the first falling edge in Shift-DR
  task automatic wait_padoe_high();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge tck_pad_i);
      #1;
      cycles++;
    end while (tdo_padoe_o !== 1'b1 && cycles < PADOE_TIMEOUT);
    if (tdo_padoe_o !== 1'b1)
    begin
      $display("TDO pad enable never went high after entering Shift-DR");
      $display("STATUS: FAIL");
      $fatal(1, "pad enable timeout");
    end
  endtask

  // Run-Test-Idle to Shift-IR, five bits LSB first, back to Run-Test-Idle
  task automatic shift_ir(input logic [4:0] code, output logic [4:0] tdo_bits);
    step(1'b1, 1'b0);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    for (int i = 0; i < IR_LEN; i++)
    begin
      // Last bit leaves with TMS high
      step(i == IR_LEN - 1, code[i]);
      tdo_bits[i] = tdo_pad_o;
      check("tdo_padoe_o", 32'(tdo_padoe_o), 32'd1);
    end
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
  endtask

  // DR scan of n bits, chain_sel picks which chain input carries chain_bits
  task automatic shift_dr(input int n, input logic [31:0] tdi_bits,
                          input logic [31:0] chain_bits, input logic [2:0] chain_sel,
                          input logic use_pause, input logic pause_oe,
                          output logic [31:0] tdo_bits);
    logic c;
    tdo_bits = '0;
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    wait_padoe_high();
    for (int i = 0; i < n; i++)
    begin
      if (i > 0)
        @(negedge tck_pad_i);
      c = chain_bits[i];
      tms_pad_i   = (i == n - 1);
      tdi_pad_i   = tdi_bits[i];
      // Unselected chains carry the inverse so a wrong mux arm shows up
      debug_tdi_i = chain_sel[2] ? c : ~c;
      dtmcs_tdi_i = chain_sel[1] ? c : ~c;
      dmi_tdi_i   = chain_sel[0] ? c : ~c;
      #4;
      tdo_bits[i] = tdo_pad_o;
      check("tdo_o", 32'(tdo_o), 32'(tdi_pad_i));
      check("tdo_padoe_o", 32'(tdo_padoe_o), 32'd1);
      check("shift_dr_o", 32'(shift_dr_o), 32'd1);
    end
    if (use_pause)
    begin
      // Exit1-DR, then one look at Pause-DR
      step(1'b0, 1'b0);
      step(1'b0, 1'b0);
      check("pause_dr_o", 32'(pause_dr_o), 32'd1);
      check("tdo_padoe_o in Pause-DR", 32'(tdo_padoe_o), 32'(pause_oe));
      step(1'b1, 1'b0);
    end
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
  endtask

  task automatic test_idcode_after_reset();
    logic [31:0] tdo_bits;
    int cap_before;
    int upd_before;
    cap_before = cap_count;
    upd_before = upd_count;
    shift_dr(32, 32'h0, 32'h0, 3'b000, 1'b0, 1'b0, tdo_bits);
    check("idcode", tdo_bits, IDCODE_VAL);
    step(1'b0, 1'b0);
    check("tdo_padoe_o in Run-Test-Idle", 32'(tdo_padoe_o), 32'd0);
    check("capture_dr_o cycles", 32'(cap_count - cap_before), 32'd1);
    check("update_dr_o cycles", 32'(upd_count - upd_before), 32'd1);
  endtask

  task automatic test_ir_capture();
    logic [4:0] tdo_bits;
    shift_ir(5'b00010, tdo_bits);
    // Bits out in order 1,0,1,0,0
    check("ir capture", 32'(tdo_bits), 32'(5'b00101));
  endtask

  task automatic test_bypass();
    logic [4:0]  codes [2];
    logic [4:0]  ir_bits;
    logic [31:0] data;
    logic [31:0] tdo_bits;
    codes[0] = 5'b01111;
    codes[1] = 5'b11111;
    foreach (codes[k])
    begin
      shift_ir(codes[k], ir_bits);
      step(1'b0, 1'b0);
      check("chain selects", 32'({debug_select_o, dtmcs_select_o, dmi_select_o}), 32'd0);
      data = 32'($urandom) & 32'hFFFF;
      shift_dr(16, data, 32'h0, 3'b000, 1'b0, 1'b0, tdo_bits);
      // One-bit delay, first bit out is stale
      check("bypass tdo", 32'(tdo_bits[15:1]), 32'(data[14:0]));
    end
  endtask

  task automatic test_external_chains();
    logic [4:0]  codes [3];
    logic [2:0]  mask;
    logic [4:0]  ir_bits;
    logic [31:0] tdi_data;
    logic [31:0] chain_data;
    logic [31:0] tdo_bits;
    codes[0] = 5'b01000;
    codes[1] = 5'b10000;
    codes[2] = 5'b10001;
    foreach (codes[k])
    begin
      mask = 3'b100 >> k;
      shift_ir(codes[k], ir_bits);
      step(1'b0, 1'b0);
      check("chain selects", 32'({debug_select_o, dtmcs_select_o, dmi_select_o}), 32'(mask));
      tdi_data   = 32'($urandom) & 32'hFFFF;
      chain_data = 32'($urandom) & 32'hFFFF;
      // Only the debug chain keeps the pad driven in Pause-DR
      shift_dr(16, tdi_data, chain_data, mask, 1'b1, k == 0, tdo_bits);
      check("chain tdo", tdo_bits, chain_data);
    end
  endtask

  task automatic test_tms_reset();
    logic [4:0]  ir_bits;
    logic [31:0] tdo_bits;
    shift_ir(5'b10001, ir_bits);
    step(1'b0, 1'b0);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    step(1'b1, 1'b0);
    check("shift_dr_o before TMS reset", 32'(shift_dr_o), 32'd1);
    repeat (4) step(1'b1, 1'b0);
    // Fifth high edge has landed, now in Test-Logic-Reset
    step(1'b1, 1'b0);
    check("dr state outputs", 32'({shift_dr_o, pause_dr_o, update_dr_o, capture_dr_o}), 32'd0);
    check("chain selects", 32'({debug_select_o, dtmcs_select_o, dmi_select_o}), 32'd0);
    step(1'b0, 1'b0);
    shift_dr(32, 32'h0, 32'h0, 3'b000, 1'b0, 1'b0, tdo_bits);
    check("idcode after TMS reset", tdo_bits, IDCODE_VAL);
  endtask

  initial
  begin
    void'($urandom(3580));
    trst_pad_i  = 1'b1;
    tms_pad_i   = 1'b1;
    tdi_pad_i   = 1'b0;
    debug_tdi_i = 1'b0;
    dtmcs_tdi_i = 1'b0;
    dmi_tdi_i   = 1'b0;
    repeat (3) @(posedge tck_pad_i);
    @(negedge tck_pad_i);
    trst_pad_i = 1'b0;
    // Test-Logic-Reset to Run-Test-Idle
    step(1'b0, 1'b0);
    test_idcode_after_reset();
    test_ir_capture();
    test_bypass();
    test_external_chains();
    test_tms_reset();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- project.f
src/jtag_pkg.sv
src/jtag_if.sv
src/tap_fsm.sv
src/tap_ir.sv
src/tap_data_regs.sv
src/tap_tdo_mux.sv
src/jtag_tap.sv
bench/tb_jtag_tap.sv

//--- src/jtag_if.sv
// TAP state and instruction select interfaces shared between the TAP blocks
`timescale 1ns/10ps

interface tap_state_if ();
  // Data register column
  logic test_logic_reset;
  logic run_test_idle;
  logic select_dr_scan;
  logic capture_dr;
  logic shift_dr;
  logic exit1_dr;
  logic pause_dr;
  logic exit2_dr;
  logic update_dr;
  // Instruction register column
  logic select_ir_scan;
  logic capture_ir;
  logic shift_ir;
  logic exit1_ir;
  logic pause_ir;
  logic exit2_ir;
  logic update_ir;

  // Driven by the state machine
  modport fsm (output test_logic_reset, run_test_idle, select_dr_scan, capture_dr,
               shift_dr, exit1_dr, pause_dr, exit2_dr, update_dr, select_ir_scan,
               capture_ir, shift_ir, exit1_ir, pause_ir, exit2_ir, update_ir);

  // Read by the registers, the TDO path and the top
  modport user (input test_logic_reset, run_test_idle, select_dr_scan, capture_dr,
                shift_dr, exit1_dr, pause_dr, exit2_dr, update_dr, select_ir_scan,
                capture_ir, shift_ir, exit1_ir, pause_ir, exit2_ir, update_ir);
endinterface

interface instr_sel_if ();
  // One-hot decode of the active instruction
  logic idcode_sel;
  logic bypass_sel;
  logic debug_sel;
  logic dtmcs_sel;
  logic dmi_sel;

  modport dec (output idcode_sel, bypass_sel, debug_sel, dtmcs_sel, dmi_sel);
  modport user (input idcode_sel, bypass_sel, debug_sel, dtmcs_sel, dmi_sel);
endinterface

//--- src/jtag_pkg.sv
// JTAG TAP package with the instruction set, the capture pattern and the IDCODE layout
package jtag_pkg;

  // Instruction register length, fixed by the 5-bit opcode set
  localparam int IR_LEN = 5;

  // Supported opcodes
  localparam logic [IR_LEN-1:0] OP_IDCODE = 5'b00010;
  localparam logic [IR_LEN-1:0] OP_DEBUG  = 5'b01000;
  localparam logic [IR_LEN-1:0] OP_BYPASS = 5'b01111;
  localparam logic [IR_LEN-1:0] OP_DTMCS  = 5'b10000;
  localparam logic [IR_LEN-1:0] OP_DMI    = 5'b10001;

  // Loaded in Capture-IR
  // Low two bits 01 as 1149.1 requires, rest picked for easy fault spotting
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 5'b00101;

  // IDCODE word
  // Shifted as a raw word, built and checked through the fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      // Revision of the part
      logic [3:0]  version;
      // Part number
      logic [15:0] part_number;
      // JEDEC manufacturer id, parity bit dropped
      logic [10:0] manufacturer;
      // Always 1 so an IDCODE can be told from a BYPASS bit
      logic        marker;
    } fields;
  } idcode_u;

  // Version 1, part 0x4951, manufacturer 0x0E1, marker 1
  // Field order follows the struct, MSB first, giving 32'h149511C3
  localparam idcode_u IDCODE_DEFAULT = idcode_u'({4'h1, 16'h4951, 11'h0E1, 1'b1});

endpackage

//--- src/jtag_tap.sv
// JTAG TAP controller top, joining the FSM, IR, data registers and TDO mux to the pads
`timescale 1ns/10ps

module jtag_tap #(
  parameter jtag_pkg::idcode_u IDCODE_VALUE = jtag_pkg::IDCODE_DEFAULT
) (
  // JTAG pads
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tms_pad_i,
  input  logic tdi_pad_i,
  output logic tdo_pad_o,
  output logic tdo_padoe_o,
  // DR states for the external chains
  output logic shift_dr_o,
  output logic pause_dr_o,
  output logic update_dr_o,
  output logic capture_dr_o,
  // Chain selects
  output logic debug_select_o,
  output logic dtmcs_select_o,
  output logic dmi_select_o,
  // Serial data to and from the chains
  output logic tdo_o,
  input  logic debug_tdi_i,
  input  logic dtmcs_tdi_i,
  input  logic dmi_tdi_i
);

  tap_state_if st_if ();
  instr_sel_if sel_if ();

  logic ir_tdo;
  logic idcode_tdo;
  logic bypass_tdo;

  tap_fsm u_fsm (
    .tck_pad_i  (tck_pad_i),
    .trst_pad_i (trst_pad_i),
    .tms_pad_i  (tms_pad_i),
    .st         (st_if.fsm)
  );

  tap_ir u_ir (
    .tck_pad_i  (tck_pad_i),
    .trst_pad_i (trst_pad_i),
    .tdi_pad_i  (tdi_pad_i),
    .st         (st_if.user),
    .sel        (sel_if.dec),
    .ir_tdo_o   (ir_tdo)
  );

  tap_data_regs #(
    .IDCODE_VALUE (IDCODE_VALUE)
  ) u_data_regs (
    .tck_pad_i    (tck_pad_i),
    .trst_pad_i   (trst_pad_i),
    .tdi_pad_i    (tdi_pad_i),
    .st           (st_if.user),
    .sel          (sel_if.user),
    .idcode_tdo_o (idcode_tdo),
    .bypass_tdo_o (bypass_tdo)
  );

  tap_tdo_mux u_tdo_mux (
    .tck_pad_i    (tck_pad_i),
    .trst_pad_i   (trst_pad_i),
    .st           (st_if.user),
    .sel          (sel_if.user),
    .ir_tdo_i     (ir_tdo),
    .idcode_tdo_i (idcode_tdo),
    .bypass_tdo_i (bypass_tdo),
    .debug_tdi_i  (debug_tdi_i),
    .dtmcs_tdi_i  (dtmcs_tdi_i),
    .dmi_tdi_i    (dmi_tdi_i),
    .tdo_pad_o    (tdo_pad_o),
    .tdo_padoe_o  (tdo_padoe_o)
  );

  // TDI fans out to every chain
  assign tdo_o = tdi_pad_i;

  assign shift_dr_o   = st_if.shift_dr;
  assign pause_dr_o   = st_if.pause_dr;
  assign update_dr_o  = st_if.update_dr;
  assign capture_dr_o = st_if.capture_dr;

  assign debug_select_o = sel_if.debug_sel;
  assign dtmcs_select_o = sel_if.dtmcs_sel;
  assign dmi_select_o   = sel_if.dmi_sel;

endmodule

//--- src/tap_data_regs.sv
// IDCODE and BYPASS data registers, each presented on TDO through a falling-edge flop
`timescale 1ns/10ps

module tap_data_regs #(
  parameter jtag_pkg::idcode_u IDCODE_VALUE = jtag_pkg::IDCODE_DEFAULT
) (
  input  logic      tck_pad_i,
  input  logic      trst_pad_i,
  input  logic      tdi_pad_i,
  tap_state_if.user st,
  instr_sel_if.user sel,
  output logic      idcode_tdo_o,
  output logic      bypass_tdo_o
);

  logic [31:0] idcode_q;
  logic        bypass_q;

  // IDCODE reloads every cycle unless it is being shifted
  // so Capture-DR always sees the fixed value
  always_ff @(posedge tck_pad_i)
  begin
    if (sel.idcode_sel & st.shift_dr)
      idcode_q <= {tdi_pad_i, idcode_q[31:1]};
    else
      idcode_q <= IDCODE_VALUE.raw;
  end

  // One-bit bypass stage
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      bypass_q <= 1'b0;
    else if (st.shift_dr)
      bypass_q <= tdi_pad_i;
  end

  // Outputs change on the falling edge
  always_ff @(negedge tck_pad_i)
  begin
    idcode_tdo_o <= idcode_q[0];
    bypass_tdo_o <= bypass_q;
  end

  // Marker bit tells an IDCODE apart from a bypass bit on the chain
  a_idcode_marker : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    IDCODE_VALUE.fields.marker == 1'b1);

endmodule

//--- src/tap_fsm.sv
// TAP controller state machine, one flop per state, with the five-TMS-high reset filter
`timescale 1ns/10ps

module tap_fsm (
  input  logic     tck_pad_i,
  input  logic     trst_pad_i,
  input  logic     tms_pad_i,
  tap_state_if.fsm st
);

  // State bit positions
  localparam int TLR      = 0;
  localparam int RTI      = 1;
  localparam int SEL_DR   = 2;
  localparam int CAP_DR   = 3;
  localparam int SHIFT_DR = 4;
  localparam int EXIT1_DR = 5;
  localparam int PAUSE_DR = 6;
  localparam int EXIT2_DR = 7;
  localparam int UPD_DR   = 8;
  localparam int SEL_IR   = 9;
  localparam int CAP_IR   = 10;
  localparam int SHIFT_IR = 11;
  localparam int EXIT1_IR = 12;
  localparam int PAUSE_IR = 13;
  localparam int EXIT2_IR = 14;
  localparam int UPD_IR   = 15;

  localparam logic [15:0] TLR_ONLY = 16'b1 << TLR;

  logic [3:0]  tms_q;
  logic        tms_reset;
  logic [15:0] state_q;
  logic [15:0] state_d;

  // Last four sampled TMS values
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      tms_q <= '0;
    else
      tms_q <= {tms_q[2:0], tms_pad_i};
  end

  // Current TMS plus four stored highs
  assign tms_reset = tms_pad_i & (&tms_q);

  // IEEE 1149.1 graph, each state set from its predecessors
  always_comb
  begin
    state_d           = '0;
    state_d[TLR]      = tms_pad_i & (state_q[TLR] | state_q[SEL_IR]);
    state_d[RTI]      = ~tms_pad_i & (state_q[TLR] | state_q[RTI] |
                                      state_q[UPD_DR] | state_q[UPD_IR]);
    state_d[SEL_DR]   = tms_pad_i & (state_q[RTI] | state_q[UPD_DR] | state_q[UPD_IR]);
    state_d[CAP_DR]   = ~tms_pad_i & state_q[SEL_DR];
    state_d[SHIFT_DR] = ~tms_pad_i & (state_q[CAP_DR] | state_q[SHIFT_DR] | state_q[EXIT2_DR]);
    state_d[EXIT1_DR] = tms_pad_i & (state_q[CAP_DR] | state_q[SHIFT_DR]);
    state_d[PAUSE_DR] = ~tms_pad_i & (state_q[EXIT1_DR] | state_q[PAUSE_DR]);
    state_d[EXIT2_DR] = tms_pad_i & state_q[PAUSE_DR];
    state_d[UPD_DR]   = tms_pad_i & (state_q[EXIT1_DR] | state_q[EXIT2_DR]);
    // IR column mirrors the DR column
    state_d[SEL_IR]   = tms_pad_i & state_q[SEL_DR];
    state_d[CAP_IR]   = ~tms_pad_i & state_q[SEL_IR];
    state_d[SHIFT_IR] = ~tms_pad_i & (state_q[CAP_IR] | state_q[SHIFT_IR] | state_q[EXIT2_IR]);
    state_d[EXIT1_IR] = tms_pad_i & (state_q[CAP_IR] | state_q[SHIFT_IR]);
    state_d[PAUSE_IR] = ~tms_pad_i & (state_q[EXIT1_IR] | state_q[PAUSE_IR]);
    state_d[EXIT2_IR] = tms_pad_i & state_q[PAUSE_IR];
    state_d[UPD_IR]   = tms_pad_i & (state_q[EXIT1_IR] | state_q[EXIT2_IR]);
  end

  // State flops, filter wins over the graph
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      state_q <= TLR_ONLY;
    else if (tms_reset)
      state_q <= TLR_ONLY;
    else
      state_q <= state_d;
  end

  assign st.test_logic_reset = state_q[TLR];
  assign st.run_test_idle    = state_q[RTI];
  assign st.select_dr_scan   = state_q[SEL_DR];
  assign st.capture_dr       = state_q[CAP_DR];
  assign st.shift_dr         = state_q[SHIFT_DR];
  assign st.exit1_dr         = state_q[EXIT1_DR];
  assign st.pause_dr         = state_q[PAUSE_DR];
  assign st.exit2_dr         = state_q[EXIT2_DR];
  assign st.update_dr        = state_q[UPD_DR];
  assign st.select_ir_scan   = state_q[SEL_IR];
  assign st.capture_ir       = state_q[CAP_IR];
  assign st.shift_ir         = state_q[SHIFT_IR];
  assign st.exit1_ir         = state_q[EXIT1_IR];
  assign st.pause_ir         = state_q[PAUSE_IR];
  assign st.exit2_ir         = state_q[EXIT2_IR];
  assign st.update_ir        = state_q[UPD_IR];

  // Exactly one state visible to the other blocks
  a_state_onehot : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    $onehot({st.test_logic_reset, st.run_test_idle, st.select_dr_scan, st.capture_dr,
             st.shift_dr, st.exit1_dr, st.pause_dr, st.exit2_dr, st.update_dr,
             st.select_ir_scan, st.capture_ir, st.shift_ir, st.exit1_ir, st.pause_ir,
             st.exit2_ir, st.update_ir}));

  // Five TMS highs always land in Test-Logic-Reset
  a_tms_reset : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    tms_pad_i [*5] |=> st.test_logic_reset);

endmodule

//--- src/tap_ir.sv
// TAP instruction register with capture, shift, update and one-hot instruction decode
`timescale 1ns/10ps

module tap_ir (
  input  logic      tck_pad_i,
  input  logic      trst_pad_i,
  input  logic      tdi_pad_i,
  tap_state_if.user st,
  instr_sel_if.dec  sel,
  output logic      ir_tdo_o
);
  import jtag_pkg::*;

  logic [IR_LEN-1:0] ir_shift_q;
  logic [IR_LEN-1:0] ir_latched_q;
  logic [IR_LEN-1:0] ir_active;

  // Shift register, fixed pattern on capture, LSB out first
  always_ff @(posedge tck_pad_i)
  begin
    if (st.capture_ir)
      ir_shift_q <= IR_CAPTURE;
    else if (st.shift_ir)
      ir_shift_q <= {tdi_pad_i, ir_shift_q[IR_LEN-1:1]};
  end

  // Shifted bit held across the low phase of TCK
  always_ff @(negedge tck_pad_i)
  begin
    ir_tdo_o <= ir_shift_q[0];
  end

  // Latched instruction
  // Back to IDCODE on TRST and while in Test-Logic-Reset
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      ir_latched_q <= OP_IDCODE;
    else if (st.test_logic_reset)
      ir_latched_q <= OP_IDCODE;
    else if (st.update_ir)
      ir_latched_q <= ir_shift_q;
  end

  // Test-Logic-Reset selects IDCODE at once
  // so the TMS filter clears the selects on the edge it fires
  assign ir_active = st.test_logic_reset ? OP_IDCODE : ir_latched_q;

  // Instruction decode, anything unknown behaves as BYPASS
  always_comb
  begin
    sel.idcode_sel = 1'b0;
    sel.bypass_sel = 1'b0;
    sel.debug_sel  = 1'b0;
    sel.dtmcs_sel  = 1'b0;
    sel.dmi_sel    = 1'b0;
    case (ir_active)
      OP_IDCODE: sel.idcode_sel = 1'b1;
      OP_DEBUG:  sel.debug_sel  = 1'b1;
      OP_BYPASS: sel.bypass_sel = 1'b1;
      OP_DTMCS:  sel.dtmcs_sel  = 1'b1;
      OP_DMI:    sel.dmi_sel    = 1'b1;
      default:   sel.bypass_sel = 1'b1;
    endcase
  end

  // The data registers and TDO mux rely on a single active select
  a_sel_onehot : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    $onehot({sel.idcode_sel, sel.bypass_sel, sel.debug_sel, sel.dtmcs_sel, sel.dmi_sel}));

endmodule

//--- src/tap_tdo_mux.sv
// TDO source selection and pad enable, both retimed to the falling edge of TCK
`timescale 1ns/10ps

module tap_tdo_mux (
  input  logic      tck_pad_i,
  input  logic      trst_pad_i,
  tap_state_if.user st,
  instr_sel_if.user sel,
  input  logic      ir_tdo_i,
  input  logic      idcode_tdo_i,
  input  logic      bypass_tdo_i,
  input  logic      debug_tdi_i,
  input  logic      dtmcs_tdi_i,
  input  logic      dmi_tdi_i,
  output logic      tdo_pad_o,
  output logic      tdo_padoe_o
);

  // Falling-edge copies of the mux controls
  logic shift_ir_q;
  logic idcode_q;
  logic bypass_q;
  logic debug_q;
  logic dtmcs_q;
  logic dmi_q;

  always_ff @(negedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
    begin
      shift_ir_q  <= 1'b0;
      // IDCODE is the instruction after reset
      idcode_q    <= 1'b1;
      bypass_q    <= 1'b0;
      debug_q     <= 1'b0;
      dtmcs_q     <= 1'b0;
      dmi_q       <= 1'b0;
      tdo_padoe_o <= 1'b0;
    end
    else
    begin
      shift_ir_q  <= st.shift_ir;
      idcode_q    <= sel.idcode_sel;
      bypass_q    <= sel.bypass_sel;
      debug_q     <= sel.debug_sel;
      dtmcs_q     <= sel.dtmcs_sel;
      dmi_q       <= sel.dmi_sel;
      // Debug chain keeps the pad driven through Pause-DR
      tdo_padoe_o <= st.shift_ir | st.shift_dr | (st.pause_dr & sel.debug_sel);
    end
  end

  // IR bit during Shift-IR, otherwise the selected data path
  always_comb
  begin
    if (shift_ir_q)
      tdo_pad_o = ir_tdo_i;
    else
    begin
      case (1'b1)
        idcode_q: tdo_pad_o = idcode_tdo_i;
        debug_q:  tdo_pad_o = debug_tdi_i;
        dtmcs_q:  tdo_pad_o = dtmcs_tdi_i;
        dmi_q:    tdo_pad_o = dmi_tdi_i;
        bypass_q: tdo_pad_o = bypass_tdo_i;
        default:  tdo_pad_o = 1'b0;
      endcase
    end
  end

endmodule
